// File: Bender.yml
package:
  name: sensor_readout

sources:
  - verilog/i2c_pkg.sv
  - verilog/disp_pkg.sv
  - verilog/i2c_master.sv
  - verilog/i2c_arbiter.sv
  - verilog/adc_poller.sv
  - verilog/uart_bridge.sv
  - verilog/seg_display.sv
  - verilog/sensor_top.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/sensor_chk.sv
      - verif/sensor_tb.sv

// File: filelist.f
verilog/i2c_pkg.sv
verilog/disp_pkg.sv
verilog/i2c_master.sv
verilog/i2c_arbiter.sv
verilog/adc_poller.sv
verilog/uart_bridge.sv
verilog/seg_display.sv
verilog/sensor_top.sv
verif/tb_clock.sv
verif/sensor_chk.sv
verif/sensor_tb.sv

// File: verif/sensor_chk.sv
//**********************************************************
// grant rules of the shared I2C arbiter
// relies on the arbiter's internal gnt_0 and gnt_1 names
//**********************************************************
`timescale 1ns/100ps
module sensor_chk (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic gnt_0,
	input logic gnt_1,
	input logic done_0,
	input logic done_1,
	input logic m_start,
	input logic m_busy
);
	int fail_count = 0;

	grant_exclusive: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(gnt_0 && gnt_1))
	else begin
		$error("both requesters hold a grant");
		fail_count++;
	end

	// owner cannot change in the middle of a frame
	grant_stable: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		m_busy |-> $stable({gnt_0, gnt_1}))
	else begin
		$error("grant changed while the master was busy");
		fail_count++;
	end

	done_exclusive: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(done_0 && done_1))
	else begin
		$error("done routed to both requesters");
		fail_count++;
	end

	start_when_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		m_start |-> !m_busy)
	else begin
		$error("start issued while the master was busy");
		fail_count++;
	end

endmodule

bind i2c_arbiter sensor_chk u_chk (
	.sys_clk  (sys_clk),
	.sys_rst_n(sys_rst_n),
	.gnt_0    (gnt_0),
	.gnt_1    (gnt_1),
	.done_0   (done_0),
	.done_1   (done_1),
	.m_start  (m_start),
	.m_busy   (m_busy)
);

// File: verif/sensor_tb.sv
//**********************************************************
// small timing parameters so polls and host commands overlap
// I2C slave answers the ADC address and one other device
//**********************************************************
`timescale 1ns/100ps
module sensor_tb;
	import i2c_pkg::*;
	import disp_pkg::*;

	localparam int TB_SCL_DIV      = 4;
	localparam int TB_POLL_CYCLES  = 2000;
	localparam int TB_CLKS_PER_BIT = 16;
	localparam int TB_SCAN_CYCLES  = 8;

	localparam logic [6:0] OTHER_DEV = 7'h2a;

	localparam int N_WRITES       = 6;
	localparam int N_READS        = 6;
	localparam int N_NACK_CMDS    = 2;
	localparam int N_HOLD_READS   = 1;
	localparam int DISP_ROUNDS    = 3;
	localparam int CONT_ROUNDS    = 4;
	localparam int CMDS_PER_ROUND = 2;

	// a read frame is 39 bit times of four quarters each
	localparam int FRAME_CLKS     = 39 * 4 * TB_SCL_DIV;
	localparam int BYTE_CLKS      = 10 * TB_CLKS_PER_BIT;
	localparam int CMD_CLKS       = 5 * BYTE_CLKS + 2 * FRAME_CLKS;
	localparam int POLL_WAIT_CLKS = 3 * (TB_POLL_CYCLES + FRAME_CLKS);
	localparam int DISP_CLKS      = 2 * DIGIT_COUNT * TB_SCAN_CYCLES;
	localparam int N_CMDS         = N_WRITES + N_READS + N_NACK_CMDS + N_HOLD_READS
		+ CONT_ROUNDS * CMDS_PER_ROUND;
	localparam int N_POLL_WAITS   = DISP_ROUNDS + 3 + CONT_ROUNDS;
	localparam int N_DISP         = 1 + DISP_ROUNDS + 2 + CONT_ROUNDS;
	localparam int TIMEOUT_CLKS   = 2 * (N_CMDS * CMD_CLKS + N_POLL_WAITS * POLL_WAIT_CLKS
		+ N_DISP * DISP_CLKS) + 16;

	logic       sys_clk;
	logic       sys_rst_n;
	logic       uart_rx;
	logic       uart_tx;
	logic       scl;
	wire        sda;
	logic [7:0] seg_number;
	logic [7:0] seg_choice;

	// slave model state
	logic       sda_drv = 1'b0;
	logic       adc_nack = 1'b0;
	int         adc_reads = 0;
	int         adc_nacks = 0;
	logic [7:0] regs [2][256];
	logic [6:0] last_wr_dev;
	logic [7:0] last_wr_reg;
	logic [7:0] last_wr_data;
	integer     seed = 32'hfd4e;

	pullup (sda);
	assign sda = sda_drv ? 1'b0 : 1'bz;

	tb_clock #(
		.PERIOD_NS(100.0)
	) u_clock (
		.sys_clk(sys_clk)
	);

	sensor_top #(
		.SCL_DIV     (TB_SCL_DIV),
		.POLL_CYCLES (TB_POLL_CYCLES),
		.CLKS_PER_BIT(TB_CLKS_PER_BIT),
		.SCAN_CYCLES (TB_SCAN_CYCLES)
	) uut (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.uart_rx   (uart_rx),
		.uart_tx   (uart_tx),
		.scl       (scl),
		.sda       (sda),
		.seg_number(seg_number),
		.seg_choice(seg_choice)
	);

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			fail_run($sformatf("CHECK FAILED %s expected 0x%0h actual 0x%0h",
				name, expected, actual));
		end
	endtask

	function automatic int dev_index(input logic [6:0] dev);
		if (dev == ADC_DEV_ADDR) begin
			return 0;
		end
		if (dev == OTHER_DEV) begin
			return 1;
		end
		return -1;
	endfunction

	// ones on digit 0 and leading zeros dark
	function automatic logic [7:0] expected_seg(input logic [7:0] value, input int digit);
		logic [3:0] code;
		code = CODE_BLANK;
		if (digit == 0) begin
			code = 4'(value % 10);
		end else if (digit == 1 && value >= 10) begin
			code = 4'((value / 10) % 10);
		end else if (digit == 2 && value >= 100) begin
			code = 4'(value / 100);
		end
		return seg_pattern(code);
	endfunction

	function automatic int lit_digit(input logic [7:0] choice);
		int idx;
		idx = 0;
		for (int i = 0; i < DIGIT_COUNT; i++) begin
			if (choice[i] == 1'b0) begin
				idx = i;
			end
		end
		return idx;
	endfunction

	// one byte from the master
	// restart flags a START inside the byte
	task automatic i2c_recv_byte(output logic [7:0] data, output logic restart);
		logic bit_val;
		data    = '0;
		restart = 1'b0;
		for (int i = 0; i < 8; i++) begin
			@(posedge scl);
			bit_val = sda;
			@(negedge scl or negedge sda);
			if (scl === 1'b1) begin
				restart = 1'b1;
				return;
			end
			data = {data[6:0], bit_val};
		end
	endtask

	task automatic i2c_ack();
		sda_drv = 1'b1;
		@(negedge scl);
		sda_drv = 1'b0;
	endtask

	task automatic i2c_send_byte(input logic [7:0] data);
		for (int i = 7; i >= 0; i--) begin
			sda_drv = ~data[i];
			@(negedge scl);
		end
		sda_drv = 1'b0;
	endtask

	initial begin : i2c_slave
		logic [7:0] byte_in;
		logic [7:0] ptr;
		logic       restart;
		int         dsel;
		forever begin
			// START is sda falling while scl is high
			do @(negedge sda); while (scl !== 1'b1);
			i2c_recv_byte(byte_in, restart);
			dsel = dev_index(byte_in[7:1]);
			if (dsel == 0 && adc_nack) begin
				adc_nacks++;
				continue;
			end
			if (dsel < 0 || byte_in[0]) begin
				continue;
			end
			i2c_ack();
			i2c_recv_byte(ptr, restart);
			i2c_ack();
			i2c_recv_byte(byte_in, restart);
			if (!restart) begin
				regs[dsel][ptr] = byte_in;
				last_wr_dev     = (dsel == 0) ? ADC_DEV_ADDR : OTHER_DEV;
				last_wr_reg     = ptr;
				last_wr_data    = byte_in;
				i2c_ack();
			end else begin
				i2c_recv_byte(byte_in, restart);
				if (dev_index(byte_in[7:1]) != dsel || !byte_in[0]) begin
					fail_run("I2C master sent a wrong address after the repeated START");
				end
				i2c_ack();
				if (dsel == 0 && ptr == ADC_REG_ADDR) begin
					adc_reads++;
				end
				i2c_send_byte(regs[dsel][ptr]);
			end
		end
	end

	task automatic uart_send(input logic [7:0] data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			uart_rx = frame[i];
			repeat (TB_CLKS_PER_BIT) @(negedge sys_clk);
		end
	endtask

	// samples every bit in its middle
	task automatic uart_recv(output logic [7:0] data);
		data = '0;
		while (uart_tx !== 1'b0) @(negedge sys_clk);
		repeat (TB_CLKS_PER_BIT / 2) @(negedge sys_clk);
		if (uart_tx !== 1'b0) begin
			fail_run("UART reply start bit ended early");
		end
		for (int i = 0; i < 8; i++) begin
			repeat (TB_CLKS_PER_BIT) @(negedge sys_clk);
			data[i] = uart_tx;
		end
		repeat (TB_CLKS_PER_BIT) @(negedge sys_clk);
		if (uart_tx !== 1'b1) begin
			fail_run("UART reply stop bit was low");
		end
	endtask

	task automatic host_command(input logic rw, input logic [6:0] dev,
		input logic [7:0] reg_a, input logic [7:0] wdata,
		output logic [7:0] status, output logic [7:0] data);
		uart_send({rw, dev});
		uart_send(reg_a);
		uart_send(wdata);
		uart_recv(status);
		uart_recv(data);
	endtask

	task automatic wait_adc_reads(input int count);
		int target;
		target = adc_reads + count;
		while (adc_reads < target) @(negedge sys_clk);
	endtask

	task automatic wait_adc_nacks(input int count);
		int target;
		target = adc_nacks + count;
		while (adc_nacks < target) @(negedge sys_clk);
	endtask

	// watch two full scan rounds
	task automatic check_display(input string name, input logic [7:0] value);
		logic [7:0] seen;
		int         idx;
		seen = '0;
		repeat (DISP_CLKS) begin
			@(negedge sys_clk);
			if (seg_choice !== 8'hff) begin
				check_value({name, " one digit lit"}, 1, $countones(~seg_choice));
				idx = lit_digit(seg_choice);
				check_value($sformatf("%s digit %0d", name, idx),
					expected_seg(value, idx), seg_number);
				seen[idx] = 1'b1;
			end
		end
		check_value({name, " all digits scanned"}, 8'hff, seen);
	endtask

	initial begin : watchdog
		#(TIMEOUT_CLKS * 100.0);
		fail_run("timeout, the DUT stopped answering");
	end

	// a failing bound assertion ends the run at once
	initial begin : assertion_watch
		wait (uut.u_arbiter.u_chk.fail_count != 0);
		fail_run("a bound arbiter assertion failed");
	end

	initial begin : main
		logic [7:0] status;
		logic [7:0] data;
		logic [7:0] value;
		logic [7:0] old_value;
		logic [7:0] wvalue;
		logic [7:0] reg_a;
		logic [6:0] dev;
		logic       rw;
		uart_rx   = 1'b1;
		sys_rst_n = 1'b0;
		for (int d = 0; d < 2; d++) begin
			for (int a = 0; a < 256; a++) begin
				regs[d][a] = 8'(a * 7 + d * 8'h5a + 8'h13);
			end
		end
		regs[0][ADC_REG_ADDR] = 8'h00;
		repeat (16) @(negedge sys_clk);
		sys_rst_n = 1'b1;

		check_value("reset uart_tx", 1, uart_tx);
		check_value("reset scl", 1, scl);
		check_value("reset sda released", 1, sda);
		check_value("reset seg_choice", 8'hff, seg_choice);
		check_display("reset display", 8'd0);

		for (int r = 0; r < DISP_ROUNDS; r++) begin
			value = 8'($random(seed));
			regs[0][ADC_REG_ADDR] = value;
			wait_adc_reads(2);
			check_display("adc display", value);
		end

		for (int i = 0; i < N_WRITES; i++) begin
			reg_a  = 8'($random(seed));
			wvalue = 8'($random(seed));
			host_command(1'b0, OTHER_DEV, reg_a, wvalue, status, data);
			check_value("host write status", STATUS_ACK, status);
			check_value("host write echo", wvalue, data);
			check_value("host write register", wvalue, regs[1][reg_a]);
			check_value("host write last device", OTHER_DEV, last_wr_dev);
			check_value("host write last register", reg_a, last_wr_reg);
			check_value("host write last data", wvalue, last_wr_data);
		end

		for (int i = 0; i < N_READS; i++) begin
			dev   = 1'($random(seed)) ? ADC_DEV_ADDR : OTHER_DEV;
			reg_a = 8'($random(seed));
			// keep the ADC result register to the poller
			if (dev == ADC_DEV_ADDR && reg_a == ADC_REG_ADDR) begin
				reg_a = 8'h01;
			end
			host_command(1'b1, dev, reg_a, 8'h00, status, data);
			check_value("host read status", STATUS_ACK, status);
			check_value("host read data", regs[dev_index(dev)][reg_a], data);
		end

		for (int i = 0; i < N_NACK_CMDS; i++) begin
			do dev = 7'($random(seed)); while (dev_index(dev) >= 0);
			host_command(1'(i), dev, 8'($random(seed)), 8'h3c, status, data);
			check_value("host nack status", STATUS_NACK, status);
		end

		// ADC stops answering so the display holds the old sample
		old_value = regs[0][ADC_REG_ADDR];
		adc_nack  = 1'b1;
		wait_adc_nacks(1);
		value = 8'($random(seed));
		if (value == old_value) begin
			value = ~value;
		end
		regs[0][ADC_REG_ADDR] = value;
		// leave a different byte in the master's read data
		reg_a = 8'($random(seed));
		if (regs[1][reg_a] == old_value) begin
			regs[1][reg_a] = ~old_value;
		end
		host_command(1'b1, OTHER_DEV, reg_a, 8'h00, status, data);
		check_value("read before nacked poll", regs[1][reg_a], data);
		wait_adc_nacks(1);
		check_display("nacked poll display", old_value);
		adc_nack = 1'b0;
		wait_adc_reads(2);
		check_display("display after nack", value);

		for (int r = 0; r < CONT_ROUNDS; r++) begin
			value = 8'($random(seed));
			regs[0][ADC_REG_ADDR] = value;
			for (int c = 0; c < CMDS_PER_ROUND; c++) begin
				rw     = 1'($random(seed));
				reg_a  = 8'($random(seed));
				wvalue = 8'($random(seed));
				host_command(rw, OTHER_DEV, reg_a, wvalue, status, data);
				check_value("contention status", STATUS_ACK, status);
				if (rw) begin
					check_value("contention read data", regs[1][reg_a], data);
				end else begin
					check_value("contention write echo", wvalue, data);
					check_value("contention write register", wvalue, regs[1][reg_a]);
				end
			end
			wait_adc_reads(2);
			check_display("contention display", value);
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

// File: verif/tb_clock.sv
//**********************************************************
// free-running clock, starts low, no jitter
//**********************************************************
`timescale 1ns/100ps
module tb_clock #(
	parameter real PERIOD_NS = 100.0
) (
	output logic sys_clk
);

	initial begin
		sys_clk = 1'b0;
		forever #(PERIOD_NS / 2.0) sys_clk = ~sys_clk;
	end

endmodule

// File: verilog/adc_poller.sv
//**********************************************************
// a read that ends in nack keeps the previous sample
//**********************************************************
`timescale 1ns/100ps
module adc_poller #(
	parameter int POLL_CYCLES = i2c_pkg::POLL_CYCLES_DEF
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	output logic       req,
	input  logic       done,
	input  logic [7:0] rdata,
	input  logic       nack,
	output logic [7:0] sample
);
	localparam int CNT_W = $clog2(POLL_CYCLES + 1);

	logic [CNT_W-1:0] poll_cnt;
	logic             poll_due;

	assign poll_due = (poll_cnt == CNT_W'(POLL_CYCLES - 1));

	// free-running, keeps counting while a read waits for the bus
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			poll_cnt <= '0;
		end else if (poll_due) begin
			poll_cnt <= '0;
		end else begin
			poll_cnt <= poll_cnt + 1'b1;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			req    <= 1'b0;
			sample <= '0;
		end else if (done) begin
			req <= 1'b0;
			if (!nack) begin
				sample <= rdata;
			end
		end else if (poll_due) begin
			req <= 1'b1;
		end
	end

endmodule

// File: verilog/disp_pkg.sv
//**********************************************************
// segment outputs are active low, bit 0 is segment a
// codes 10 to 15 leave the digit dark
//**********************************************************
package disp_pkg;

	localparam int DIGIT_COUNT = 8;

	// 1 ms per digit at 50 MHz
	localparam int SCAN_CYCLES_DEF = 50_000;

	localparam logic [3:0] CODE_BLANK = 4'hf;

	// pattern order is a..g then dp
	function automatic logic [7:0] seg_pattern(input logic [3:0] code);
		case (code)
		4'd0:    return 8'hc0;
		4'd1:    return 8'hf9;
		4'd2:    return 8'ha4;
		4'd3:    return 8'hb0;
		4'd4:    return 8'h99;
		4'd5:    return 8'h92;
		4'd6:    return 8'h82;
		4'd7:    return 8'hf8;
		4'd8:    return 8'h80;
		4'd9:    return 8'h90;
		default: return 8'hff;
		endcase
	endfunction

endpackage

// File: verilog/i2c_arbiter.sv
//**********************************************************
// requester 0 wins the first tie after reset
// requests must stay stable until their done pulse
//**********************************************************
`timescale 1ns/100ps
module i2c_arbiter (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       req_0,
	input  logic       rw_0,
	input  logic [6:0] dev_0,
	input  logic [7:0] reg_0,
	input  logic [7:0] wdata_0,
	output logic       done_0,
	input  logic       req_1,
	input  logic       rw_1,
	input  logic [6:0] dev_1,
	input  logic [7:0] reg_1,
	input  logic [7:0] wdata_1,
	output logic       done_1,
	output logic       m_start,
	output logic       m_rw,
	output logic [6:0] m_dev,
	output logic [7:0] m_reg,
	output logic [7:0] m_wdata,
	input  logic       m_busy,
	input  logic       m_done
);
	logic gnt_0;
	logic gnt_1;
	logic last_1;
	logic launch;
	logic pick_1;

	// on a tie, serve whoever did not go last
	assign pick_1 = req_1 & (~req_0 | ~last_1);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			gnt_0   <= 1'b0;
			gnt_1   <= 1'b0;
			last_1  <= 1'b1;
			launch  <= 1'b0;
			m_start <= 1'b0;
		end else begin
			launch  <= 1'b0;
			m_start <= launch;
			if (!gnt_0 && !gnt_1) begin
				if (!m_busy && (req_0 || req_1)) begin
					gnt_0  <= ~pick_1;
					gnt_1  <= pick_1;
					launch <= 1'b1;
				end
			end else if (m_done) begin
				gnt_0  <= 1'b0;
				gnt_1  <= 1'b0;
				last_1 <= gnt_1;
			end
		end
	end

	assign m_rw    = gnt_1 ? rw_1 : rw_0;
	assign m_dev   = gnt_1 ? dev_1 : dev_0;
	assign m_reg   = gnt_1 ? reg_1 : reg_0;
	assign m_wdata = gnt_1 ? wdata_1 : wdata_0;

	assign done_0 = m_done & gnt_0;
	assign done_1 = m_done & gnt_1;

endmodule

// File: verilog/i2c_master.sv
//**********************************************************
// one-byte register read or write per request
// no clock stretching, sda needs an external pull-up
//**********************************************************
`timescale 1ns/100ps
module i2c_master #(
	parameter int SCL_DIV = i2c_pkg::I2C_SCL_DIV_DEF
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       start,
	input  logic       rw,
	input  logic [6:0] dev,
	input  logic [7:0] reg_addr,
	input  logic [7:0] wdata,
	output logic       busy,
	output logic       done,
	output logic [7:0] rdata,
	output logic       nack,
	output logic       scl,
	inout  wire        sda
);
	localparam int DIV_W = $clog2(SCL_DIV + 1);

	localparam logic [2:0] ST_IDLE  = 3'd0;
	localparam logic [2:0] ST_START = 3'd1;
	localparam logic [2:0] ST_WRITE = 3'd2;
	localparam logic [2:0] ST_READ  = 3'd3;
	localparam logic [2:0] ST_STOP  = 3'd4;

	localparam logic [1:0] STG_ADDR_W = 2'd0;
	localparam logic [1:0] STG_REG    = 2'd1;
	localparam logic [1:0] STG_DATA   = 2'd2;
	localparam logic [1:0] STG_ADDR_R = 2'd3;

	logic [DIV_W-1:0] div_cnt;
	logic             tick;
	logic [2:0]       state;
	logic [1:0]       phase;
	logic [3:0]       bit_cnt;
	logic [1:0]       stage;
	logic [7:0]       shreg;
	logic             sda_low;
	logic             rw_l;
	logic [6:0]       dev_l;
	logic [7:0]       reg_l;
	logic [7:0]       wdata_l;

	assign sda  = sda_low ? 1'b0 : 1'bz;
	assign tick = (div_cnt == DIV_W'(SCL_DIV - 1));

	// quarter-period timer, idle between frames
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			div_cnt <= '0;
		end else if (state == ST_IDLE || tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// request fields for the whole frame
	always_ff @(posedge sys_clk) begin
		if (start && state == ST_IDLE) begin
			rw_l    <= rw;
			dev_l   <= dev;
			reg_l   <= reg_addr;
			wdata_l <= wdata;
		end
	end

	// each bit is four quarters: setup, rise, high, fall
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= ST_IDLE;
			phase   <= '0;
			bit_cnt <= '0;
			stage   <= STG_ADDR_W;
			shreg   <= '0;
			rdata   <= '0;
			scl     <= 1'b1;
			sda_low <= 1'b0;
			busy    <= 1'b0;
			done    <= 1'b0;
			nack    <= 1'b0;
		end else begin
			done <= 1'b0;
			if (state == ST_IDLE) begin
				phase <= '0;
				if (start) begin
					state <= ST_START;
					stage <= STG_ADDR_W;
					busy  <= 1'b1;
					nack  <= 1'b0;
				end
			end else if (tick) begin
				phase <= phase + 2'd1;
				case (state)
				ST_START: begin
					case (phase)
					2'd0: begin
						scl     <= 1'b0;
						sda_low <= 1'b0;
					end
					2'd1: scl <= 1'b1;
					// sda falls while scl is high
					2'd2: sda_low <= 1'b1;
					default: begin
						scl     <= 1'b0;
						shreg   <= {dev_l, stage == STG_ADDR_R};
						bit_cnt <= '0;
						state   <= ST_WRITE;
					end
					endcase
				end
				ST_WRITE: begin
					case (phase)
					// bit 8 releases sda for the slave ack
					2'd0: sda_low <= (bit_cnt == 4'd8) ? 1'b0 : ~shreg[7];
					2'd1: scl <= 1'b1;
					2'd3: begin
						scl <= 1'b0;
						if (bit_cnt != 4'd8) begin
							shreg   <= {shreg[6:0], 1'b0};
							bit_cnt <= bit_cnt + 4'd1;
						end else if (sda) begin
							nack  <= 1'b1;
							state <= ST_STOP;
						end else begin
							bit_cnt <= '0;
							case (stage)
							STG_ADDR_W: begin
								stage <= STG_REG;
								shreg <= reg_l;
							end
							STG_REG: begin
								if (rw_l) begin
									stage <= STG_ADDR_R;
									state <= ST_START;
								end else begin
									stage <= STG_DATA;
									shreg <= wdata_l;
								end
							end
							STG_DATA: state <= ST_STOP;
							default:  state <= ST_READ;
							endcase
						end
					end
					default: ;
					endcase
				end
				ST_READ: begin
					case (phase)
					// released on bit 8 too, which is the master nack
					2'd0: sda_low <= 1'b0;
					2'd1: scl <= 1'b1;
					2'd3: begin
						scl <= 1'b0;
						if (bit_cnt != 4'd8) begin
							shreg   <= {shreg[6:0], sda};
							bit_cnt <= bit_cnt + 4'd1;
						end else begin
							rdata <= shreg;
							state <= ST_STOP;
						end
					end
					default: ;
					endcase
				end
				default: begin
					case (phase)
					2'd0: sda_low <= 1'b1;
					2'd1: scl <= 1'b1;
					2'd2: sda_low <= 1'b0;
					default: begin
						busy  <= 1'b0;
						done  <= 1'b1;
						state <= ST_IDLE;
					end
					endcase
				end
				endcase
			end
		end
	end

endmodule

// File: verilog/i2c_pkg.sv
//**********************************************************
// default timing assumes a 50 MHz system clock
// 100 kHz SCL and 115200 baud UART at that clock
//**********************************************************
package i2c_pkg;

	// ADC on the shared bus
	localparam logic [6:0] ADC_DEV_ADDR = 7'h54;
	localparam logic [7:0] ADC_REG_ADDR = 8'h00;

	// first reply byte sent back to the host
	localparam logic [7:0] STATUS_ACK  = 8'h00;
	localparam logic [7:0] STATUS_NACK = 8'h01;

	// system clocks per quarter SCL period
	localparam int I2C_SCL_DIV_DEF = 125;

	// about ten ADC reads per second
	localparam int POLL_CYCLES_DEF = 5_000_000;

	// one UART bit time
	localparam int UART_CLKS_PER_BIT_DEF = 434;

endpackage

// File: verilog/seg_display.sv
//**********************************************************
// digit 0 is the ones digit, digits 3 to 7 stay dark
// select lines are active low
//**********************************************************
`timescale 1ns/100ps
module seg_display #(
	parameter int SCAN_CYCLES = disp_pkg::SCAN_CYCLES_DEF
) (
	input  logic                              sys_clk,
	input  logic                              sys_rst_n,
	input  logic [7:0]                        value,
	output logic [7:0]                        seg_number,
	output logic [disp_pkg::DIGIT_COUNT-1:0] seg_choice
);
	import disp_pkg::*;

	localparam int CNT_W = $clog2(SCAN_CYCLES + 1);
	localparam int IDX_W = $clog2(DIGIT_COUNT);

	logic [CNT_W-1:0] scan_cnt;
	logic [IDX_W-1:0] scan_idx;
	logic [IDX_W-1:0] next_idx;
	logic [3:0]       ones;
	logic [3:0]       tens;
	logic [3:0]       hund;
	logic [3:0]       digit_code;

	always_comb begin
		ones = 4'(value % 8'd10);
		tens = 4'(value / 8'd10 % 8'd10);
		hund = 4'(value / 8'd100);
	end

	// leading zeros dark, a zero value still shows one 0
	always_comb begin
		case (scan_idx)
		3'd0:    digit_code = ones;
		3'd1:    digit_code = (value >= 8'd10) ? tens : CODE_BLANK;
		3'd2:    digit_code = (value >= 8'd100) ? hund : CODE_BLANK;
		default: digit_code = CODE_BLANK;
		endcase
	end

	assign seg_number = seg_pattern(digit_code);
	assign next_idx   = (scan_idx == IDX_W'(DIGIT_COUNT - 1)) ? '0 : scan_idx + 1'b1;

	// starts on the last digit so the first step lands on digit 0
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scan_cnt   <= '0;
			scan_idx   <= IDX_W'(DIGIT_COUNT - 1);
			seg_choice <= '1;
		end else if (scan_cnt == CNT_W'(SCAN_CYCLES - 1)) begin
			scan_cnt   <= '0;
			scan_idx   <= next_idx;
			seg_choice <= ~(DIGIT_COUNT'(1) << next_idx);
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

endmodule

// File: verilog/sensor_top.sv
//**********************************************************
// sda is open drain and needs a pull-up on the board
// poller is requester 0, host bridge is requester 1
//**********************************************************
`timescale 1ns/100ps
module sensor_top #(
	parameter int SCL_DIV      = i2c_pkg::I2C_SCL_DIV_DEF,
	parameter int POLL_CYCLES  = i2c_pkg::POLL_CYCLES_DEF,
	parameter int CLKS_PER_BIT = i2c_pkg::UART_CLKS_PER_BIT_DEF,
	parameter int SCAN_CYCLES  = disp_pkg::SCAN_CYCLES_DEF
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       uart_rx,
	output logic       uart_tx,
	output logic       scl,
	inout  wire        sda,
	output logic [7:0] seg_number,
	output logic [7:0] seg_choice
);
	import i2c_pkg::*;

	logic       poll_req;
	logic       poll_done;
	logic [7:0] sample;
	logic       host_req;
	logic       host_rw;
	logic [6:0] host_dev;
	logic [7:0] host_reg;
	logic [7:0] host_wdata;
	logic       host_done;
	logic       m_start;
	logic       m_rw;
	logic [6:0] m_dev;
	logic [7:0] m_reg;
	logic [7:0] m_wdata;
	logic       m_busy;
	logic       m_done;
	logic [7:0] m_rdata;
	logic       m_nack;

	adc_poller #(
		.POLL_CYCLES(POLL_CYCLES)
	) u_poller (
		.sys_clk  (sys_clk),
		.sys_rst_n(sys_rst_n),
		.req      (poll_req),
		.done     (poll_done),
		.rdata    (m_rdata),
		.nack     (m_nack),
		.sample   (sample)
	);

	uart_bridge #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_bridge (
		.sys_clk  (sys_clk),
		.sys_rst_n(sys_rst_n),
		.uart_rx  (uart_rx),
		.uart_tx  (uart_tx),
		.req      (host_req),
		.rw       (host_rw),
		.dev      (host_dev),
		.reg_addr (host_reg),
		.wdata    (host_wdata),
		.done     (host_done),
		.rdata    (m_rdata),
		.nack     (m_nack)
	);

	// the poller always reads the ADC result register
	i2c_arbiter u_arbiter (
		.sys_clk  (sys_clk),
		.sys_rst_n(sys_rst_n),
		.req_0    (poll_req),
		.rw_0     (1'b1),
		.dev_0    (ADC_DEV_ADDR),
		.reg_0    (ADC_REG_ADDR),
		.wdata_0  (8'h00),
		.done_0   (poll_done),
		.req_1    (host_req),
		.rw_1     (host_rw),
		.dev_1    (host_dev),
		.reg_1    (host_reg),
		.wdata_1  (host_wdata),
		.done_1   (host_done),
		.m_start  (m_start),
		.m_rw     (m_rw),
		.m_dev    (m_dev),
		.m_reg    (m_reg),
		.m_wdata  (m_wdata),
		.m_busy   (m_busy),
		.m_done   (m_done)
	);

	i2c_master #(
		.SCL_DIV(SCL_DIV)
	) u_master (
		.sys_clk  (sys_clk),
		.sys_rst_n(sys_rst_n),
		.start    (m_start),
		.rw       (m_rw),
		.dev      (m_dev),
		.reg_addr (m_reg),
		.wdata    (m_wdata),
		.busy     (m_busy),
		.done     (m_done),
		.rdata    (m_rdata),
		.nack     (m_nack),
		.scl      (scl),
		.sda      (sda)
	);

	seg_display #(
		.SCAN_CYCLES(SCAN_CYCLES)
	) u_display (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.value     (sample),
		.seg_number(seg_number),
		.seg_choice(seg_choice)
	);

endmodule

// File: verilog/uart_bridge.sv
//**********************************************************
// 8N1 frames, command is {rw, dev}, reg, wdata
// reply is status then data; bytes during a command are lost
//**********************************************************
`timescale 1ns/100ps
module uart_bridge #(
	parameter int CLKS_PER_BIT = i2c_pkg::UART_CLKS_PER_BIT_DEF
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       uart_rx,
	output logic       uart_tx,
	output logic       req,
	output logic       rw,
	output logic [6:0] dev,
	output logic [7:0] reg_addr,
	output logic [7:0] wdata,
	input  logic       done,
	input  logic [7:0] rdata,
	input  logic       nack
);
	import i2c_pkg::*;

	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

	localparam logic [1:0] RX_IDLE  = 2'd0;
	localparam logic [1:0] RX_START = 2'd1;
	localparam logic [1:0] RX_DATA  = 2'd2;
	localparam logic [1:0] RX_STOP  = 2'd3;

	logic [1:0]       rx_sync;
	logic [1:0]       rx_state;
	logic [CNT_W-1:0] rx_cnt;
	logic [2:0]       rx_bits;
	logic [7:0]       rx_shift;
	logic             rx_vld;
	logic             half_end;
	logic             bit_end;
	logic             take_byte;
	logic [1:0]       cmd_idx;
	logic             tx_active;
	logic             tx_second;
	logic [3:0]       tx_bits;
	logic [CNT_W-1:0] tx_cnt;
	logic [9:0]       tx_shift;
	logic [7:0]       reply;

	assign half_end  = (rx_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1));
	assign bit_end   = (rx_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign take_byte = rx_vld & ~req & ~tx_active;
	assign uart_tx   = tx_shift[0];

	// receiver, samples each bit in its middle
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_sync  <= 2'b11;
			rx_state <= RX_IDLE;
			rx_cnt   <= '0;
			rx_bits  <= '0;
			rx_vld   <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], uart_rx};
			rx_vld  <= 1'b0;
			rx_cnt  <= rx_cnt + 1'b1;
			case (rx_state)
			RX_IDLE: begin
				rx_cnt <= '0;
				if (!rx_sync[1]) begin
					rx_state <= RX_START;
				end
			end
			RX_START: if (half_end) begin
				rx_cnt   <= '0;
				rx_bits  <= '0;
				rx_state <= rx_sync[1] ? RX_IDLE : RX_DATA;
			end
			RX_DATA: if (bit_end) begin
				rx_cnt  <= '0;
				rx_bits <= rx_bits + 3'd1;
				if (rx_bits == 3'd7) begin
					rx_state <= RX_STOP;
				end
			end
			default: if (bit_end) begin
				rx_vld   <= rx_sync[1];
				rx_state <= RX_IDLE;
			end
			endcase
		end
	end

	// lsb arrives first
	always_ff @(posedge sys_clk) begin
		if (rx_state == RX_DATA && bit_end) begin
			rx_shift <= {rx_sync[1], rx_shift[7:1]};
		end
	end

	always_ff @(posedge sys_clk) begin
		if (take_byte) begin
			case (cmd_idx)
			2'd0:    {rw, dev} <= rx_shift;
			2'd1:    reg_addr <= rx_shift;
			default: wdata <= rx_shift;
			endcase
		end
		if (done && !tx_active) begin
			reply <= rw ? rdata : wdata;
		end
	end

	// command sequencing and the two-byte reply
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			req       <= 1'b0;
			cmd_idx   <= '0;
			tx_active <= 1'b0;
			tx_second <= 1'b0;
			tx_bits   <= '0;
			tx_cnt    <= '0;
			tx_shift  <= '1;
		end else begin
			if (take_byte) begin
				cmd_idx <= (cmd_idx == 2'd2) ? 2'd0 : cmd_idx + 2'd1;
				if (cmd_idx == 2'd2) begin
					req <= 1'b1;
				end
			end
			if (tx_active) begin
				if (tx_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
					tx_cnt <= '0;
					if (tx_bits != 4'd9) begin
						tx_shift <= {1'b1, tx_shift[9:1]};
						tx_bits  <= tx_bits + 4'd1;
					end else if (tx_second) begin
						tx_shift  <= {1'b1, reply, 1'b0};
						tx_bits   <= '0;
						tx_second <= 1'b0;
					end else begin
						tx_active <= 1'b0;
					end
				end else begin
					tx_cnt <= tx_cnt + 1'b1;
				end
			end else if (done) begin
				req       <= 1'b0;
				tx_active <= 1'b1;
				tx_second <= 1'b1;
				tx_bits   <= '0;
				tx_cnt    <= '0;
				tx_shift  <= {1'b1, nack ? STATUS_NACK : STATUS_ACK, 1'b0};
			end
		end
	end

endmodule
